//--- hw/client_pkg.sv
//////////////////////////////
// shared definitions for the packet client
// field widths, register map, reset values
// and the checker state type
//////////////////////////////
package client_pkg;

	typedef logic [31:0] word_t;
	typedef logic [15:0] serial_t;
	typedef logic [7:0]  len_t;
	typedef logic [7:0]  dest_t;
	typedef logic [15:0] addr_t;
	typedef logic [4:0]  fill_t;

	localparam int FIFO_DEPTH = 16;

	// address bits 15:6, base 0x1000
	localparam logic [9:0] STATUS_ADDR_PREFIX = 10'h040;
	localparam word_t CLIENT_ID     = 32'h434c4e54;
	localparam word_t UNMAPPED_WORD = 32'h123;

	//////////////////////////////
	// register offsets
	//////////////////////////////
	localparam logic [5:0] REG_SCRATCH     = 6'h0;
	localparam logic [5:0] REG_ID          = 6'h1;
	localparam logic [5:0] REG_TX_CTRL     = 6'h2;
	localparam logic [5:0] REG_RX_CTRL     = 6'h3;
	localparam logic [5:0] REG_PKT_LEN     = 6'h4;
	localparam logic [5:0] REG_TX_DEST     = 6'h5;
	localparam logic [5:0] REG_RX_DEST     = 6'h6;
	localparam logic [5:0] REG_HIGH_THR    = 6'h7;
	localparam logic [5:0] REG_LOW_THR     = 6'h8;
	localparam logic [5:0] REG_PKT_CNT     = 6'h9;
	localparam logic [5:0] REG_BAD_TERM    = 6'ha;
	localparam logic [5:0] REG_BAD_SERIAL  = 6'hb;
	localparam logic [5:0] REG_BAD_DEST    = 6'hc;
	localparam logic [5:0] REG_LAST_SERIAL = 6'hd;
	localparam logic [5:0] REG_FILL        = 6'he;

	// reset values of the control registers
	localparam len_t  PKT_LEN_RST  = 8'd4;
	localparam len_t  PKT_LEN_MIN  = 8'd2;
	localparam dest_t DEST_RST     = 8'h5a;
	localparam fill_t HIGH_THR_RST = 5'd12;
	localparam fill_t LOW_THR_RST  = 5'd4;

	typedef enum logic {
		CHK_IDLE,
		CHK_BODY
	} check_state_t;

endpackage

//--- hw/packet_gen.sv
`timescale 1ns/1ns
//////////////////////////////
// packet generator
// header word then numbered payload words,
// serial counter with an optional skipped serial
//////////////////////////////
module packet_gen (
	input  logic              clk_status,
	input  logic              rst_n,
	input  logic              gen_enable,
	input  logic              skip_serial,
	input  client_pkg::len_t  pkt_len,
	input  client_pkg::dest_t tx_dest,
	input  logic              throttle,
	output client_pkg::word_t gen_data,
	output logic              gen_sop,
	output logic              gen_eop,
	output logic              gen_wr
);
	import client_pkg::*;

	logic    in_pkt;
	logic    skip_pend;
	len_t    word_idx;
	len_t    cur_len;
	serial_t serial;
	logic    emit;
	logic    last_word;

	// a new packet starts only from idle, so dropping gen_enable never cuts one short
	assign emit      = !throttle && (in_pkt || gen_enable);
	assign last_word = in_pkt && (word_idx == len_t'(cur_len - 8'd1));

	always_ff @(posedge clk_status or negedge rst_n) begin
		if (!rst_n) begin
			in_pkt    <= 1'b0;
			skip_pend <= 1'b0;
			word_idx  <= '0;
			cur_len   <= '0;
			serial    <= '0;
			gen_wr    <= 1'b0;
			gen_sop   <= 1'b0;
			gen_eop   <= 1'b0;
		end else begin
			gen_wr  <= emit;
			gen_sop <= emit && !in_pkt;
			gen_eop <= emit && last_word;
			if (emit) begin
				if (!in_pkt) begin
					// length is captured with the header
					in_pkt   <= 1'b1;
					cur_len  <= pkt_len;
					word_idx <= 8'd1;
				end else if (last_word) begin
					in_pkt    <= 1'b0;
					serial    <= serial + (skip_pend ? 16'd2 : 16'd1);
					skip_pend <= 1'b0;
				end else begin
					word_idx <= word_idx + 8'd1;
				end
			end
			// a pulse on the final word applies to the following packet
			if (skip_serial) begin
				skip_pend <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_status) begin
		if (emit) begin
			if (!in_pkt) begin
				gen_data <= {serial, pkt_len, tx_dest};
			end else begin
				gen_data <= {serial, 8'd0, word_idx};
			end
		end
	end

endmodule

//--- hw/loop_fifo.sv
`timescale 1ns/1ns
//////////////////////////////
// loopback buffer
// word memory with sop and eop flags,
// fill count and hysteresis throttle
//////////////////////////////
module loop_fifo (
	input  logic              clk_status,
	input  logic              rst_n,
	input  client_pkg::word_t gen_data,
	input  logic              gen_sop,
	input  logic              gen_eop,
	input  logic              gen_wr,
	input  logic              fifo_rd,
	input  client_pkg::fill_t high_threshold,
	input  client_pkg::fill_t low_threshold,
	output client_pkg::word_t rd_data,
	output logic              rd_sop,
	output logic              rd_eop,
	output logic              rd_valid,
	output logic              throttle,
	output client_pkg::fill_t fill
);
	import client_pkg::*;

	logic [33:0] mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	logic rd_en;

	// read strobe from the checker, taken only when a word is held
	assign rd_en = fifo_rd && (fill != '0);

	always_ff @(posedge clk_status) begin
		if (gen_wr) begin
			mem[wr_ptr] <= {gen_sop, gen_eop, gen_data};
		end
		if (rd_en) begin
			{rd_sop, rd_eop, rd_data} <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk_status or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fill     <= '0;
			rd_valid <= 1'b0;
			throttle <= 1'b0;
		end else begin
			rd_valid <= rd_en;
			if (gen_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({gen_wr, rd_en})
				2'b10:   fill <= fill + 5'd1;
				2'b01:   fill <= fill - 5'd1;
				default: fill <= fill;
			endcase
			// hysteresis, holds between the two thresholds
			if (fill >= high_threshold) begin
				throttle <= 1'b1;
			end else if (fill <= low_threshold) begin
				throttle <= 1'b0;
			end
		end
	end

endmodule

//--- hw/packet_check.sv
`timescale 1ns/1ns
//////////////////////////////
// packet checker
// drains the buffer, checks header, serial
// and framing, keeps the error counters
//////////////////////////////
module packet_check (
	input  logic                clk_status,
	input  logic                rst_n,
	input  client_pkg::word_t   rd_data,
	input  logic                rd_sop,
	input  logic                rd_eop,
	input  logic                rd_valid,
	input  logic                drain_stop,
	input  logic                clr_cntrs,
	input  client_pkg::dest_t   rx_dest,
	output logic                fifo_rd,
	output client_pkg::word_t   pkt_cnt,
	output client_pkg::word_t   bad_term_cnt,
	output client_pkg::word_t   bad_serial_cnt,
	output client_pkg::word_t   bad_dest_cnt,
	output client_pkg::serial_t last_serial
);
	import client_pkg::*;

	check_state_t state;
	len_t    cur_len;
	len_t    word_idx;
	logic    first_pkt;
	logic    serial_bad;
	logic    dest_bad;
	serial_t hdr_serial;
	len_t    hdr_len;
	logic    hdr_serial_bad;
	logic    hdr_dest_bad;
	logic    at_last;
	logic    pkt_done;
	logic    term_bad;
	logic    done_serial_bad;
	logic    done_dest_bad;

	assign hdr_serial     = rd_data[31:16];
	assign hdr_len        = rd_data[15:8];
	assign hdr_serial_bad = !first_pkt && (hdr_serial != serial_t'(last_serial + 16'd1));
	assign hdr_dest_bad   = rd_data[7:0] != rx_dest;
	assign at_last        = word_idx == len_t'(cur_len - 8'd1);

	// which word closes a packet, and whether its framing was right
	always_comb begin
		pkt_done        = 1'b0;
		term_bad        = 1'b0;
		done_serial_bad = serial_bad;
		done_dest_bad   = dest_bad;
		if (rd_valid) begin
			if (state == CHK_IDLE) begin
				done_serial_bad = hdr_serial_bad;
				done_dest_bad   = hdr_dest_bad;
				if (rd_sop && rd_eop) begin
					pkt_done = 1'b1;
					term_bad = hdr_len != 8'd1;
				end
			end else if (rd_sop) begin
				// new header inside a packet, that packet is lost
				pkt_done = 1'b1;
				term_bad = 1'b1;
			end else if (rd_eop || at_last) begin
				pkt_done = 1'b1;
				term_bad = !(rd_eop && at_last);
			end
		end
	end

	always_ff @(posedge clk_status or negedge rst_n) begin
		if (!rst_n) begin
			state          <= CHK_IDLE;
			fifo_rd        <= 1'b0;
			cur_len        <= '0;
			word_idx       <= '0;
			first_pkt      <= 1'b1;
			serial_bad     <= 1'b0;
			dest_bad       <= 1'b0;
			last_serial    <= '0;
			pkt_cnt        <= '0;
			bad_term_cnt   <= '0;
			bad_serial_cnt <= '0;
			bad_dest_cnt   <= '0;
		end else begin
			fifo_rd <= !drain_stop;
			if (rd_valid) begin
				case (state)
					CHK_IDLE: begin
						// words before a header are dropped
						if (rd_sop) begin
							serial_bad  <= hdr_serial_bad;
							dest_bad    <= hdr_dest_bad;
							last_serial <= hdr_serial;
							first_pkt   <= 1'b0;
							cur_len     <= hdr_len;
							word_idx    <= 8'd1;
							if (!rd_eop) begin
								state <= CHK_BODY;
							end
						end
					end
					default: begin
						if (pkt_done) begin
							state <= CHK_IDLE;
						end else begin
							word_idx <= word_idx + 8'd1;
						end
					end
				endcase
			end
			if (pkt_done) begin
				pkt_cnt        <= pkt_cnt + 32'd1;
				bad_term_cnt   <= bad_term_cnt + {31'd0, term_bad};
				bad_serial_cnt <= bad_serial_cnt + {31'd0, done_serial_bad};
				bad_dest_cnt   <= bad_dest_cnt + {31'd0, done_dest_bad};
			end
			if (clr_cntrs) begin
				first_pkt      <= 1'b1;
				pkt_cnt        <= '0;
				bad_term_cnt   <= '0;
				bad_serial_cnt <= '0;
				bad_dest_cnt   <= '0;
			end
		end
	end

endmodule

//--- hw/client_regs.sv
`timescale 1ns/1ns
//////////////////////////////
// status register port
// registered bus inputs, prefix decode,
// control registers and read mux
//////////////////////////////
module client_regs (
	input  logic                clk_status,
	input  logic                rst_n,
	input  client_pkg::addr_t   status_addr,
	input  logic                status_read,
	input  logic                status_write,
	input  client_pkg::word_t   status_writedata,
	output client_pkg::word_t   status_readdata,
	output logic                status_readdata_valid,
	output logic                gen_enable,
	output logic                skip_serial,
	output client_pkg::len_t    pkt_len,
	output client_pkg::dest_t   tx_dest,
	output client_pkg::dest_t   rx_dest,
	output client_pkg::fill_t   high_threshold,
	output client_pkg::fill_t   low_threshold,
	output logic                clr_cntrs,
	output logic                drain_stop,
	input  client_pkg::word_t   pkt_cnt,
	input  client_pkg::word_t   bad_term_cnt,
	input  client_pkg::word_t   bad_serial_cnt,
	input  client_pkg::word_t   bad_dest_cnt,
	input  client_pkg::serial_t last_serial,
	input  client_pkg::fill_t   fill
);
	import client_pkg::*;

	logic       read_r;
	logic       write_r;
	logic       addr_sel_r;
	logic [5:0] addr_r;
	word_t      writedata_r;
	word_t      scratch;
	word_t      rd_word;
	len_t       wr_len;

	assign wr_len = writedata_r[7:0];

	//////////////////////////////
	// bus input stage
	//////////////////////////////
	always_ff @(posedge clk_status) begin
		addr_r      <= status_addr[5:0];
		addr_sel_r  <= status_addr[15:6] == STATUS_ADDR_PREFIX;
		writedata_r <= status_writedata;
	end

	always_ff @(posedge clk_status or negedge rst_n) begin
		if (!rst_n) begin
			read_r                <= 1'b0;
			write_r               <= 1'b0;
			status_readdata_valid <= 1'b0;
			scratch               <= '0;
			gen_enable            <= 1'b0;
			skip_serial           <= 1'b0;
			clr_cntrs             <= 1'b0;
			drain_stop            <= 1'b0;
			pkt_len               <= PKT_LEN_RST;
			tx_dest               <= DEST_RST;
			rx_dest               <= DEST_RST;
			high_threshold        <= HIGH_THR_RST;
			low_threshold         <= LOW_THR_RST;
		end else begin
			read_r                <= status_read;
			write_r               <= status_write;
			status_readdata_valid <= read_r && addr_sel_r;
			skip_serial           <= 1'b0;
			if (write_r && addr_sel_r) begin
				case (addr_r)
					REG_SCRATCH: scratch <= writedata_r;
					REG_TX_CTRL: begin
						gen_enable  <= writedata_r[0];
						skip_serial <= writedata_r[1];
					end
					REG_RX_CTRL: begin
						clr_cntrs  <= writedata_r[0];
						drain_stop <= writedata_r[1];
					end
					// the generator needs a header and at least one payload word
					REG_PKT_LEN:  pkt_len <= (wr_len < PKT_LEN_MIN) ? PKT_LEN_MIN : wr_len;
					REG_TX_DEST:  tx_dest <= writedata_r[7:0];
					REG_RX_DEST:  rx_dest <= writedata_r[7:0];
					REG_HIGH_THR: high_threshold <= writedata_r[4:0];
					REG_LOW_THR:  low_threshold <= writedata_r[4:0];
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////
	// read mux
	//////////////////////////////
	always_comb begin
		case (addr_r)
			REG_SCRATCH:     rd_word = scratch;
			REG_ID:          rd_word = CLIENT_ID;
			REG_TX_CTRL:     rd_word = {31'd0, gen_enable};
			REG_RX_CTRL:     rd_word = {30'd0, drain_stop, clr_cntrs};
			REG_PKT_LEN:     rd_word = {24'd0, pkt_len};
			REG_TX_DEST:     rd_word = {24'd0, tx_dest};
			REG_RX_DEST:     rd_word = {24'd0, rx_dest};
			REG_HIGH_THR:    rd_word = {27'd0, high_threshold};
			REG_LOW_THR:     rd_word = {27'd0, low_threshold};
			REG_PKT_CNT:     rd_word = pkt_cnt;
			REG_BAD_TERM:    rd_word = bad_term_cnt;
			REG_BAD_SERIAL:  rd_word = bad_serial_cnt;
			REG_BAD_DEST:    rd_word = bad_dest_cnt;
			REG_LAST_SERIAL: rd_word = {16'd0, last_serial};
			REG_FILL:        rd_word = {27'd0, fill};
			default:         rd_word = UNMAPPED_WORD;
		endcase
	end

	// reads outside the prefix are ignored
	always_ff @(posedge clk_status) begin
		if (read_r && addr_sel_r) begin
			status_readdata <= rd_word;
		end
	end

endmodule

//--- hw/packet_client.sv
`timescale 1ns/1ns
//////////////////////////////
// packet client top level
// register port, generator, loopback
// buffer and checker
//////////////////////////////
module packet_client (
	input  logic              clk_status,
	input  logic              rst_n,
	input  client_pkg::addr_t status_addr,
	input  logic              status_read,
	input  logic              status_write,
	input  client_pkg::word_t status_writedata,
	output client_pkg::word_t status_readdata,
	output logic              status_readdata_valid
);
	import client_pkg::*;

	// control from the register port
	logic  gen_enable;
	logic  skip_serial;
	len_t  pkt_len;
	dest_t tx_dest;
	dest_t rx_dest;
	fill_t high_threshold;
	fill_t low_threshold;
	logic  clr_cntrs;
	logic  drain_stop;

	// status back to the register port
	word_t   pkt_cnt;
	word_t   bad_term_cnt;
	word_t   bad_serial_cnt;
	word_t   bad_dest_cnt;
	serial_t last_serial;
	fill_t   fill;

	// generator to buffer
	word_t gen_data;
	logic  gen_sop;
	logic  gen_eop;
	logic  gen_wr;
	logic  throttle;

	// buffer to checker
	logic  fifo_rd;
	word_t rd_data;
	logic  rd_sop;
	logic  rd_eop;
	logic  rd_valid;

	client_regs u_regs (
		.clk_status            (clk_status),
		.rst_n                 (rst_n),
		.status_addr           (status_addr),
		.status_read           (status_read),
		.status_write          (status_write),
		.status_writedata      (status_writedata),
		.status_readdata       (status_readdata),
		.status_readdata_valid (status_readdata_valid),
		.gen_enable            (gen_enable),
		.skip_serial           (skip_serial),
		.pkt_len               (pkt_len),
		.tx_dest               (tx_dest),
		.rx_dest               (rx_dest),
		.high_threshold        (high_threshold),
		.low_threshold         (low_threshold),
		.clr_cntrs             (clr_cntrs),
		.drain_stop            (drain_stop),
		.pkt_cnt               (pkt_cnt),
		.bad_term_cnt          (bad_term_cnt),
		.bad_serial_cnt        (bad_serial_cnt),
		.bad_dest_cnt          (bad_dest_cnt),
		.last_serial           (last_serial),
		.fill                  (fill)
	);

	packet_gen u_gen (
		.clk_status  (clk_status),
		.rst_n       (rst_n),
		.gen_enable  (gen_enable),
		.skip_serial (skip_serial),
		.pkt_len     (pkt_len),
		.tx_dest     (tx_dest),
		.throttle    (throttle),
		.gen_data    (gen_data),
		.gen_sop     (gen_sop),
		.gen_eop     (gen_eop),
		.gen_wr      (gen_wr)
	);

	loop_fifo u_fifo (
		.clk_status     (clk_status),
		.rst_n          (rst_n),
		.gen_data       (gen_data),
		.gen_sop        (gen_sop),
		.gen_eop        (gen_eop),
		.gen_wr         (gen_wr),
		.fifo_rd        (fifo_rd),
		.high_threshold (high_threshold),
		.low_threshold  (low_threshold),
		.rd_data        (rd_data),
		.rd_sop         (rd_sop),
		.rd_eop         (rd_eop),
		.rd_valid       (rd_valid),
		.throttle       (throttle),
		.fill           (fill)
	);

	packet_check u_check (
		.clk_status     (clk_status),
		.rst_n          (rst_n),
		.rd_data        (rd_data),
		.rd_sop         (rd_sop),
		.rd_eop         (rd_eop),
		.rd_valid       (rd_valid),
		.drain_stop     (drain_stop),
		.clr_cntrs      (clr_cntrs),
		.rx_dest        (rx_dest),
		.fifo_rd        (fifo_rd),
		.pkt_cnt        (pkt_cnt),
		.bad_term_cnt   (bad_term_cnt),
		.bad_serial_cnt (bad_serial_cnt),
		.bad_dest_cnt   (bad_dest_cnt),
		.last_serial    (last_serial)
	);

endmodule

//--- tests/packet_client_chk.sv
`timescale 1ns/1ns
//////////////////////////////
// assertions on the loopback buffer
// and the status read path
//////////////////////////////
module packet_client_chk (
	input logic              clk_status,
	input logic              rst_n,
	input logic              gen_wr,
	input logic              fifo_rd,
	input logic              rd_valid,
	input logic              status_readdata_valid,
	input client_pkg::fill_t fill
);
	import client_pkg::*;

	logic rd_take;

	// read strobe that the buffer actually serves
	assign rd_take = fifo_rd && (fill != '0);

	// throttle keeps the generator off a full buffer
	no_write_when_full: assert property (@(posedge clk_status) disable iff (!rst_n)
		gen_wr |-> (fill != fill_t'(FIFO_DEPTH)))
		else $error("write into a full buffer");

	no_read_when_empty: assert property (@(posedge clk_status) disable iff (!rst_n)
		(fifo_rd && (fill == '0)) |=> !rd_valid)
		else $error("read from an empty buffer returned a word");

	valid_after_read: assert property (@(posedge clk_status) disable iff (!rst_n)
		rd_take |=> rd_valid)
		else $error("rd_valid missing one cycle after a read");

	valid_only_after_read: assert property (@(posedge clk_status) disable iff (!rst_n)
		rd_valid |-> $past(rd_take))
		else $error("rd_valid without a read in the previous cycle");

	single_cycle_read_valid: assert property (@(posedge clk_status) disable iff (!rst_n)
		status_readdata_valid |=> !status_readdata_valid)
		else $error("status_readdata_valid high two cycles running");

endmodule

// the top level carries the buffer ports and the register port outputs
bind packet_client packet_client_chk u_chk (
	.clk_status            (clk_status),
	.rst_n                 (rst_n),
	.gen_wr                (gen_wr),
	.fifo_rd               (fifo_rd),
	.rd_valid              (rd_valid),
	.status_readdata_valid (status_readdata_valid),
	.fill                  (fill)
);

//--- tests/packet_client_tb.sv
`timescale 1ns/1ns
//////////////////////////////
// directed testbench for the packet client
// clock and reset, status bus tasks,
// value check and the test tasks
//////////////////////////////
module packet_client_tb;
	import client_pkg::*;

	localparam int    BUS_TIMEOUT  = 20;
	localparam int    POLL_TIMEOUT = 400;
	localparam word_t HIGH_THR     = 32'(HIGH_THR_RST);
	localparam word_t FILL_LIMIT   = 32'(HIGH_THR_RST) + 32'd2;

	logic        clk_status;
	logic        rst_n;
	addr_t       status_addr;
	logic        status_read;
	logic        status_write;
	word_t       status_writedata;
	word_t       status_readdata;
	logic        status_readdata_valid;

	packet_client u_dut (
		.clk_status            (clk_status),
		.rst_n                 (rst_n),
		.status_addr           (status_addr),
		.status_read           (status_read),
		.status_write          (status_write),
		.status_writedata      (status_writedata),
		.status_readdata       (status_readdata),
		.status_readdata_valid (status_readdata_valid)
	);

	initial begin
		clk_status = 1'b0;
		forever #10 clk_status = ~clk_status;
	end

	//////////////////////////////
	// reporting and checks
	//////////////////////////////
	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_eq(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
		end
	endtask

	task automatic apply_reset();
		@(negedge clk_status);
		rst_n = 1'b0;
		repeat (2) @(negedge clk_status);
		rst_n = 1'b1;
		@(negedge clk_status);
	endtask

	//////////////////////////////
	// status bus
	//////////////////////////////
	function automatic addr_t reg_addr(input logic [5:0] offset);
		return {STATUS_ADDR_PREFIX, offset};
	endfunction

	task automatic bus_write(input logic [5:0] offset, input word_t data);
		@(negedge clk_status);
		status_addr      = reg_addr(offset);
		status_writedata = data;
		status_write     = 1'b1;
		@(negedge clk_status);
		status_write = 1'b0;
		// input stage and then the register update
		repeat (2) @(negedge clk_status);
	endtask

	task automatic bus_read(input addr_t addr, output word_t data);
		int cycles;
		@(negedge clk_status);
		status_addr = addr;
		status_read = 1'b1;
		@(negedge clk_status);
		status_read = 1'b0;
		cycles = 1;
		while (!status_readdata_valid && cycles < BUS_TIMEOUT) begin
			@(negedge clk_status);
			cycles++;
		end
		if (!status_readdata_valid) begin
			fail_run($sformatf("read of address 0x%04h never returned valid data", addr));
		end else begin
			check_eq("read_latency", cycles, 2);
			data = status_readdata;
		end
	endtask

	task automatic reg_read(input logic [5:0] offset, output word_t data);
		bus_read(reg_addr(offset), data);
	endtask

	// a read that must not be answered
	task automatic read_expect_silent(input addr_t addr);
		int cycles;
		@(negedge clk_status);
		status_addr = addr;
		status_read = 1'b1;
		@(negedge clk_status);
		status_read = 1'b0;
		cycles = 1;
		while (!status_readdata_valid && cycles < BUS_TIMEOUT) begin
			@(negedge clk_status);
			cycles++;
		end
		if (status_readdata_valid) begin
			fail_run($sformatf("read of foreign address 0x%04h returned data", addr));
		end
	endtask

	task automatic poll_reg(input logic [5:0] offset, input bit at_least, input word_t target,
			output word_t data);
		int polls;
		bit met;
		polls = 0;
		met   = 1'b0;
		while (!met && polls < POLL_TIMEOUT) begin
			reg_read(offset, data);
			met = at_least ? (data >= target) : (data == target);
			polls++;
		end
		if (!met) begin
			fail_run($sformatf("register 0x%0h did not reach 0x%0h in time", offset, target));
		end
	endtask

	//////////////////////////////
	// shared test steps
	//////////////////////////////
	task automatic stop_and_drain();
		word_t data;
		bus_write(REG_TX_CTRL, 32'd0);
		poll_reg(REG_FILL, 1'b0, 32'd0, data);
		// last word may still sit in the read stage
		repeat (4) @(negedge clk_status);
		poll_reg(REG_FILL, 1'b0, 32'd0, data);
	endtask

	task automatic check_no_errors();
		word_t data;
		reg_read(REG_BAD_TERM, data);
		check_eq("bad_term_cnt", data, 32'd0);
		reg_read(REG_BAD_SERIAL, data);
		check_eq("bad_serial_cnt", data, 32'd0);
		reg_read(REG_BAD_DEST, data);
		check_eq("bad_dest_cnt", data, 32'd0);
	endtask

	task automatic check_fill_bounds(input word_t data);
		if (data > FILL_LIMIT) begin
			fail_run($sformatf("buffer fill %0d went above the high threshold plus 2", data));
		end else if (data < HIGH_THR) begin
			fail_run($sformatf("buffer fill %0d fell below the high threshold", data));
		end
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////
	task automatic test_register_port();
		word_t data;
		reg_read(REG_ID, data);
		check_eq("client_id", data, CLIENT_ID);
		bus_write(REG_SCRATCH, 32'h5eedc0de);
		reg_read(REG_SCRATCH, data);
		check_eq("scratch", data, 32'h5eedc0de);
		reg_read(REG_PKT_LEN, data);
		check_eq("pkt_len", data, 32'(PKT_LEN_RST));
		reg_read(REG_TX_DEST, data);
		check_eq("tx_dest", data, 32'(DEST_RST));
		reg_read(REG_RX_DEST, data);
		check_eq("rx_dest", data, 32'(DEST_RST));
		reg_read(REG_HIGH_THR, data);
		check_eq("high_threshold", data, HIGH_THR);
		reg_read(REG_LOW_THR, data);
		check_eq("low_threshold", data, 32'(LOW_THR_RST));
		// lengths below 2 are raised to 2
		bus_write(REG_PKT_LEN, 32'd1);
		reg_read(REG_PKT_LEN, data);
		check_eq("pkt_len", data, 32'd2);
		bus_write(REG_PKT_LEN, 32'(PKT_LEN_RST));
		reg_read(6'h3f, data);
		check_eq("unmapped", data, UNMAPPED_WORD);
		read_expect_silent({STATUS_ADDR_PREFIX + 10'd1, REG_ID});
	endtask

	task automatic test_clean_stream();
		word_t data;
		word_t count;
		len_t  len;
		len = len_t'(32'd2 + ($urandom % 32'd15));
		bus_write(REG_PKT_LEN, {24'd0, len});
		reg_read(REG_PKT_LEN, data);
		check_eq("pkt_len", data, {24'd0, len});
		bus_write(REG_TX_CTRL, 32'd1);
		poll_reg(REG_PKT_CNT, 1'b1, 32'd20, data);
		stop_and_drain();
		check_no_errors();
		reg_read(REG_PKT_CNT, count);
		reg_read(REG_LAST_SERIAL, data);
		check_eq("last_serial", data, count - 32'd1);
	endtask

	task automatic test_serial_gap();
		word_t data;
		word_t count;
		bus_write(REG_TX_CTRL, 32'd1);
		// enable stays set while bit 1 pulses
		bus_write(REG_TX_CTRL, 32'd3);
		reg_read(REG_TX_CTRL, data);
		check_eq("tx_ctrl", data, 32'd1);
		poll_reg(REG_BAD_SERIAL, 1'b1, 32'd1, data);
		reg_read(REG_PKT_CNT, count);
		poll_reg(REG_PKT_CNT, 1'b1, count + 32'd3, data);
		stop_and_drain();
		reg_read(REG_BAD_SERIAL, data);
		check_eq("bad_serial_cnt", data, 32'd1);
		reg_read(REG_BAD_TERM, data);
		check_eq("bad_term_cnt", data, 32'd0);
		reg_read(REG_BAD_DEST, data);
		check_eq("bad_dest_cnt", data, 32'd0);
		reg_read(REG_PKT_CNT, count);
		reg_read(REG_LAST_SERIAL, data);
		check_eq("last_serial", data, count);
	endtask

	task automatic test_dest_and_clear();
		word_t data;
		word_t count;
		bus_write(REG_RX_DEST, 32'h000000c3);
		bus_write(REG_RX_CTRL, 32'd1);
		bus_write(REG_RX_CTRL, 32'd0);
		bus_write(REG_TX_CTRL, 32'd1);
		poll_reg(REG_PKT_CNT, 1'b1, 32'd8, data);
		stop_and_drain();
		reg_read(REG_PKT_CNT, count);
		reg_read(REG_BAD_DEST, data);
		check_eq("bad_dest_cnt", data, count);
		reg_read(REG_BAD_SERIAL, data);
		check_eq("bad_serial_cnt", data, 32'd0);
		reg_read(REG_BAD_TERM, data);
		check_eq("bad_term_cnt", data, 32'd0);
		// counters held at zero while the clear bit is set
		bus_write(REG_RX_CTRL, 32'd1);
		reg_read(REG_RX_CTRL, data);
		check_eq("rx_ctrl", data, 32'd1);
		reg_read(REG_PKT_CNT, data);
		check_eq("pkt_cnt", data, 32'd0);
		check_no_errors();
		bus_write(REG_RX_CTRL, 32'd0);
		bus_write(REG_RX_DEST, 32'(DEST_RST));
	endtask

	task automatic test_back_pressure();
		word_t data;
		word_t count;
		int    i;
		// start from fresh serials
		apply_reset();
		bus_write(REG_RX_CTRL, 32'd2);
		bus_write(REG_TX_CTRL, 32'd1);
		poll_reg(REG_FILL, 1'b1, HIGH_THR, data);
		check_fill_bounds(data);
		for (i = 0; i < 8; i++) begin
			reg_read(REG_FILL, data);
			check_fill_bounds(data);
		end
		bus_write(REG_RX_CTRL, 32'd0);
		stop_and_drain();
		check_no_errors();
		reg_read(REG_PKT_CNT, count);
		reg_read(REG_LAST_SERIAL, data);
		check_eq("last_serial", data, count - 32'd1);
	endtask

	initial begin
		rst_n            = 1'b0;
		status_addr      = '0;
		status_read      = 1'b0;
		status_write     = 1'b0;
		status_writedata = '0;
		void'($urandom(32'hf294));
		apply_reset();
		test_register_port();
		test_clean_stream();
		test_serial_gap();
		test_dest_and_clear();
		test_back_pressure();
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- files.f
hw/client_pkg.sv
hw/packet_gen.sv
hw/loop_fifo.sv
hw/packet_check.sv
hw/client_regs.sv
hw/packet_client.sv
tests/packet_client_chk.sv
tests/packet_client_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the packet client testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing --assert -j 0 \
	--top-module packet_client_tb \
	-Mdir "$BUILD_DIR" \
	-f files.f

# the pipeline status is the status of tee, so a failing run still reaches the grep
"./$BUILD_DIR/Vpacket_client_tb" | tee "$LOG"

if grep -q "^Result: PASSED$" "$LOG"; then
	echo "simulation run ok"
else
	echo "simulation run reported errors, see $LOG"
	exit 1
fi
